/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = armController_tb
FILELIST = compile.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

/* compile.f */
logic/armIsaPkg.sv
logic/armPipePkg.sv
logic/instrDecoder.sv
logic/aluDecoder.sv
logic/condUnit.sv
logic/statusReg.sv
logic/pipeCtrl.sv
logic/armController.sv
verif/armController_properties.sv
verif/armController_tb.sv

/* logic/aluDecoder.sv */
`timescale 1ns/1ps

module aluDecoder (
  input  logic                    aluOp,
  input  armIsaPkg::aluCmdE       aluCmd,
  input  logic [1:0]              prevCarry,  // {C, V} from status register
  output armIsaPkg::aluOperationE aluOperation,
  output logic [2:0]              cvUpdate,
  output logic                    invertB,
  output logic                    reverseInputs,
  output logic                    aluCarry,
  output logic                    noRegWrite
);
  import armIsaPkg::*;

  cvUpdateE cvSel;

  assign cvUpdate = cvSel;

  always_comb begin
    aluOperation  = aopAdd;
    cvSel         = cvNone;
    invertB       = 1'b0;
    reverseInputs = 1'b0;
    aluCarry      = 1'b0;
    noRegWrite    = 1'b0;
    if (aluOp) begin
      case (aluCmd)
        cmdAnd, cmdTst: aluOperation = aopAnd;
        cmdEor, cmdTeq: aluOperation = aopXor;
        cmdOrr:         aluOperation = aopOr;
        cmdMov:         aluOperation = aopPass;
        cmdBic, cmdMvn: begin
          aluOperation = (aluCmd == cmdBic) ? aopAnd : aopPass;
          invertB      = 1'b1;
        end
        cmdSub, cmdCmp, cmdRsb: begin
          aluOperation  = aopSub;
          invertB       = 1'b1;
          aluCarry      = 1'b1;  // A + ~B + 1
          reverseInputs = (aluCmd == cmdRsb);
        end
        cmdSbc, cmdRsc: begin
          aluOperation  = aopSub;
          invertB       = 1'b1;
          aluCarry      = prevCarry[1];
          reverseInputs = (aluCmd == cmdRsc);
        end
        cmdAdc:         begin
          aluOperation = aopAdd;
          aluCarry     = prevCarry[1];
        end
        default:        aluOperation = aopAdd;  // ADD, CMN
      endcase
      case (aluOperation)
        aopAdd:  cvSel = cvAdd;
        aopSub:  cvSel = cvSub;
        default: cvSel = cvLogic;
      endcase
      noRegWrite = aluCmd inside {cmdTst, cmdTeq, cmdCmp, cmdCmn};  // Flags only
    end
  end

endmodule

/* logic/armController.sv */
`timescale 1ns/1ps

module armController #(
  parameter int WbCredits = 2
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                instrValid,
  input  logic [31:0]         instr,
  output logic                decCredit,
  input  armPipePkg::flagsT   aluFlags,
  output armPipePkg::exCtrlT  exCtrl,
  output logic                stallE,
  output armPipePkg::memCtrlT memCtrl,
  output armPipePkg::wbCtrlT  wbCtrl,
  input  logic                wbCreditReturn,
  output logic                pcWrPending
);
  import armIsaPkg::*;
  import armPipePkg::*;

  decCtrlT      decCtrl;
  decCtrlT      exFromDec;
  exCtrlT       exGates;
  flagsT        flags;
  flagsT        flagsNext;
  aluOperationE aluOperation;
  logic [2:0]   cvUpdate;
  logic [1:0]   flagWe;
  logic         invertB;
  logic         reverseInputs;
  logic         aluCarry;
  logic         noRegWrite;
  logic         condEx;

  instrDecoder instrDecoder_inst (
    .instr      (instr),
    .instrValid (instrValid),
    .decCtrl    (decCtrl)
  );

  aluDecoder aluDecoder_inst (
    .aluOp         (exFromDec.aluOp),
    .aluCmd        (exFromDec.aluCmd),
    .prevCarry     ({flags.c, flags.v}),
    .aluOperation  (aluOperation),
    .cvUpdate      (cvUpdate),
    .invertB       (invertB),
    .reverseInputs (reverseInputs),
    .aluCarry      (aluCarry),
    .noRegWrite    (noRegWrite)
  );

  condUnit condUnit_inst (
    .cond      (exFromDec.cond),
    .flags     (flags),
    .aluFlags  (aluFlags),
    .flagWrite (exFromDec.flagWrite),
    .condEx    (condEx),
    .flagsNext (flagsNext),
    .flagWe    (flagWe)
  );

  statusReg statusReg_inst (
    .clk       (clk),
    .rstN      (rstN),
    .en        (~stallE),  // One update per instruction leaving Execute
    .flagWe    (flagWe),
    .flagsNext (flagsNext),
    .flags     (flags)
  );

  // branchTaken is filled in by pipeCtrl
  assign exGates = '{valid:         exFromDec.valid,
                     aluSrc:        exFromDec.aluSrc,
                     aluOperation:  aluOperation,
                     cvUpdate:      cvUpdate,
                     invertB:       invertB,
                     reverseInputs: reverseInputs,
                     aluCarry:      aluCarry,
                     multEnable:    exFromDec.multSelect,
                     resultSelect:  exFromDec.resultSelect,
                     shiftOp:       exFromDec.shiftOp,
                     branchTaken:   1'b0};

  pipeCtrl #(
    .WbCredits (WbCredits)
  ) pipeCtrl_inst (
    .clk            (clk),
    .rstN           (rstN),
    .decIn          (decCtrl),
    .exFromDec      (exFromDec),
    .condEx         (condEx),
    .noRegWrite     (noRegWrite),
    .exGates        (exGates),
    .exCtrl         (exCtrl),
    .memCtrl        (memCtrl),
    .wbCtrl         (wbCtrl),
    .stallE         (stallE),
    .decCredit      (decCredit),
    .wbCreditReturn (wbCreditReturn),
    .pcWrPending    (pcWrPending)
  );

endmodule

/* logic/armIsaPkg.sv */
package armIsaPkg;

  // Coarse class from bits 27:25 and 7:4
  typedef enum logic [2:0] {
    dataImm   = 3'd0,
    dataReg   = 3'd1,
    multiply  = 3'd2,
    load      = 3'd3,
    store     = 3'd4,
    branch    = 3'd5,
    undefined = 3'd7
  } instrClassE;

  // Encoding 4'hF is unconditional space, not decoded here
  typedef enum logic [3:0] {
    condEq = 4'h0, condNe = 4'h1, condCs = 4'h2, condCc = 4'h3,
    condMi = 4'h4, condPl = 4'h5, condVs = 4'h6, condVc = 4'h7,
    condHi = 4'h8, condLs = 4'h9, condGe = 4'ha, condLt = 4'hb,
    condGt = 4'hc, condLe = 4'hd, condAl = 4'he
  } condE;

  // Data-processing opcode, instr[24:21]
  typedef enum logic [3:0] {
    cmdAnd = 4'h0, cmdEor = 4'h1, cmdSub = 4'h2, cmdRsb = 4'h3,
    cmdAdd = 4'h4, cmdAdc = 4'h5, cmdSbc = 4'h6, cmdRsc = 4'h7,
    cmdTst = 4'h8, cmdTeq = 4'h9, cmdCmp = 4'ha, cmdCmn = 4'hb,
    cmdOrr = 4'hc, cmdMov = 4'hd, cmdBic = 4'he, cmdMvn = 4'hf
  } aluCmdE;

  typedef enum logic [2:0] {
    aopAdd  = 3'd0,
    aopSub  = 3'd1,
    aopAnd  = 3'd2,
    aopOr   = 3'd3,
    aopXor  = 3'd4,
    aopPass = 3'd5
  } aluOperationE;

  // How the ALU forms the next C and V
  typedef enum logic [2:0] {
    cvNone  = 3'd0,  // Non-ALU instruction
    cvLogic = 3'd1,  // C from shifter, V kept
    cvAdd   = 3'd2,
    cvSub   = 3'd3
  } cvUpdateE;

endpackage

/* logic/armPipePkg.sv */
package armPipePkg;

  // Only one instruction may sit between fetch and decode
  localparam int DecCredits = 1;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  typedef struct packed {
    logic              valid;
    logic [1:0]        regSrc;
    logic [1:0]        immSrc;
    logic              aluSrc;
    logic              memToReg;
    logic              regWrite;
    logic              memWrite;
    logic              branch;
    logic              aluOp;
    logic              multSelect;
    logic              pcSrc;
    armIsaPkg::aluCmdE aluCmd;
    logic [1:0]        flagWrite;     // {NZ, CV}
    logic              rselect;
    logic [1:0]        resultSelect;  // {mult, reg-shifted reg}
    armIsaPkg::condE   cond;
    logic [2:0]        shiftOp;       // instr[6:4]
    logic [3:0]        rd;
  } decCtrlT;

  typedef struct packed {
    logic                    valid;
    logic                    aluSrc;
    armIsaPkg::aluOperationE aluOperation;
    logic [2:0]              cvUpdate;
    logic                    invertB;
    logic                    reverseInputs;
    logic                    aluCarry;
    logic                    multEnable;
    logic [1:0]              resultSelect;
    logic [2:0]              shiftOp;
    logic                    branchTaken;
  } exCtrlT;

  typedef struct packed {
    logic       valid;
    logic       memWrite;
    logic       memToReg;
    logic       regWrite;
    logic       pcSrc;
    logic [3:0] rd;
  } memCtrlT;

  typedef struct packed {
    logic       valid;
    logic       memToReg;
    logic       regWrite;
    logic       pcSrc;
    logic [3:0] rd;
  } wbCtrlT;

endpackage

/* logic/condUnit.sv */
`timescale 1ns/1ps

module condUnit (
  input  armIsaPkg::condE   cond,
  input  armPipePkg::flagsT flags,
  input  armPipePkg::flagsT aluFlags,
  input  logic [1:0]        flagWrite,
  output logic              condEx,
  output armPipePkg::flagsT flagsNext,
  output logic [1:0]        flagWe
);
  import armIsaPkg::*;

  logic nEqV;

  assign nEqV = (flags.n == flags.v);  // Signed greater or equal

  always_comb begin
    case (cond)
      condEq:  condEx = flags.z;
      condNe:  condEx = ~flags.z;
      condCs:  condEx = flags.c;
      condCc:  condEx = ~flags.c;
      condMi:  condEx = flags.n;
      condPl:  condEx = ~flags.n;
      condVs:  condEx = flags.v;
      condVc:  condEx = ~flags.v;
      condHi:  condEx = flags.c & ~flags.z;
      condLs:  condEx = ~flags.c | flags.z;
      condGe:  condEx = nEqV;
      condLt:  condEx = ~nEqV;
      condGt:  condEx = ~flags.z & nEqV;
      condLe:  condEx = flags.z | ~nEqV;
      condAl:  condEx = 1'b1;
      default: condEx = 1'b0;
    endcase
  end

  // Unmasked fields keep the stored value
  assign flagsNext.n = flagWrite[1] ? aluFlags.n : flags.n;
  assign flagsNext.z = flagWrite[1] ? aluFlags.z : flags.z;
  assign flagsNext.c = flagWrite[0] ? aluFlags.c : flags.c;
  assign flagsNext.v = flagWrite[0] ? aluFlags.v : flags.v;

  assign flagWe = flagWrite & {2{condEx}};

endmodule

/* logic/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder (
  input  logic [31:0]         instr,
  input  logic                instrValid,
  output armPipePkg::decCtrlT decCtrl
);
  import armIsaPkg::*;

  instrClassE iClass;
  logic [10:0] controls;
  logic        rsrForm;

  always_comb begin
    case (instr[27:25])
      3'b000:  iClass = (instr[7:4] == 4'b1001) ? multiply : dataReg;
      3'b001:  iClass = dataImm;
      3'b010,
      3'b011:  iClass = instr[20] ? load : store;
      3'b101:  iClass = branch;
      default: iClass = undefined;
    endcase
    if (instr[25] && instr[27:26] == 2'b01 && instr[4]) iClass = undefined;  // Media space
    if (instr[31:28] == 4'hf) iClass = undefined;
  end

  // {regSrc, immSrc, aluSrc, memToReg, regWrite, memWrite, branch, aluOp, multSelect}
  always_comb begin
    case (iClass)
      dataImm:  controls = 11'b00_00_1010010;
      dataReg:  controls = 11'b00_00_0010010;
      multiply: controls = 11'b00_00_0010011;
      load:     controls = {4'b00_01, ~instr[25], 6'b110000};  // Reg offset uses Rm
      store:    controls = {4'b10_01, ~instr[25], 6'b001000};
      branch:   controls = 11'b01_10_1000100;
      default:  controls = 11'b0;
    endcase
  end

  assign rsrForm = (iClass == dataReg) && instr[4];

  always_comb begin
    decCtrl = '0;
    {decCtrl.regSrc, decCtrl.immSrc, decCtrl.aluSrc, decCtrl.memToReg, decCtrl.regWrite,
     decCtrl.memWrite, decCtrl.branch, decCtrl.aluOp, decCtrl.multSelect} = controls;
    decCtrl.valid = 1'b1;
    decCtrl.rd    = decCtrl.multSelect ? instr[19:16] : instr[15:12];  // MUL Rd in 19:16
    if (decCtrl.aluOp) begin
      decCtrl.aluCmd    = aluCmdE'(instr[24:21]);
      decCtrl.flagWrite = {instr[20], instr[20] & ~decCtrl.multSelect};
    end else begin
      decCtrl.aluCmd    = cmdAdd;  // Address and target arithmetic
      decCtrl.flagWrite = 2'b00;
    end
    decCtrl.pcSrc        = (decCtrl.regWrite && decCtrl.rd == 4'hf) || decCtrl.branch;
    decCtrl.rselect      = (iClass == dataReg) && !instr[4];
    decCtrl.resultSelect = {decCtrl.multSelect, rsrForm};
    decCtrl.cond         = condE'(instr[31:28]);
    decCtrl.shiftOp      = instr[6:4];
    if (!instrValid) decCtrl = '0;  // Bubble
  end

endmodule

/* logic/pipeCtrl.sv */
`timescale 1ns/1ps

module pipeCtrl #(
  parameter int WbCredits = 2
) (
  input  logic                clk,
  input  logic                rstN,
  input  armPipePkg::decCtrlT decIn,
  output armPipePkg::decCtrlT exFromDec,
  input  logic                condEx,
  input  logic                noRegWrite,
  input  armPipePkg::exCtrlT  exGates,
  output armPipePkg::exCtrlT  exCtrl,
  output armPipePkg::memCtrlT memCtrl,
  output armPipePkg::wbCtrlT  wbCtrl,
  output logic                stallE,
  output logic                decCredit,
  input  logic                wbCreditReturn,
  output logic                pcWrPending
);
  import armPipePkg::*;

  localparam int WbCntW  = $clog2(WbCredits + 1);
  localparam int DecCntW = $clog2(DecCredits + 1);

  decCtrlT            dHold;   // Decode word parked during a stall
  decCtrlT            decCur;
  memCtrlT            memNext;
  logic [WbCntW-1:0]  wbCount;
  logic [DecCntW-1:0] decCount;
  logic               decLeave;
  logic               wbSpend;

  assign decCur   = dHold.valid ? dHold : decIn;
  assign stallE   = memCtrl.valid && (wbCount == '0);  // Nowhere to put the M item
  assign decLeave = decCur.valid & ~stallE;
  assign wbSpend  = memCtrl.valid & ~stallE;

  always_ff @(posedge clk) begin
    if (!rstN || !stallE) dHold <= '0;
    else if (decIn.valid) dHold <= decIn;
  end

  always_ff @(posedge clk) begin
    if (!rstN) exFromDec <= '0;
    else if (!stallE) exFromDec <= decCur;
  end

  always_comb begin
    exCtrl             = exGates;
    exCtrl.branchTaken = exFromDec.valid & exFromDec.branch & condEx;
  end

  // Failed condition kills every architectural write
  always_comb begin
    memNext          = '0;
    memNext.valid    = exFromDec.valid;
    memNext.memWrite = exFromDec.memWrite & condEx;
    memNext.memToReg = exFromDec.memToReg;
    memNext.regWrite = exFromDec.regWrite & condEx & ~noRegWrite;
    memNext.pcSrc    = exFromDec.pcSrc & condEx & ~noRegWrite;
    memNext.rd       = exFromDec.rd;
  end

  always_ff @(posedge clk) begin
    if (!rstN) memCtrl <= '0;
    else if (!stallE) memCtrl <= memNext;
  end

  always_ff @(posedge clk) begin
    if (!rstN || stallE) begin
      wbCtrl <= '0;  // Bubble while held
    end else begin
      wbCtrl.valid    <= memCtrl.valid;
      wbCtrl.memToReg <= memCtrl.memToReg;
      wbCtrl.regWrite <= memCtrl.regWrite;
      wbCtrl.pcSrc    <= memCtrl.pcSrc;
      wbCtrl.rd       <= memCtrl.rd;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) wbCount <= WbCntW'(WbCredits);
    else wbCount <= wbCount - WbCntW'(wbSpend) + WbCntW'(wbCreditReturn);
  end

  // Credits owed to fetch, handed out one per cycle
  always_ff @(posedge clk) begin
    if (!rstN) decCount <= DecCntW'(DecCredits);
    else decCount <= decCount - DecCntW'(decCredit) + DecCntW'(decLeave);
  end

  assign pcWrPending = (decCur.valid & decCur.pcSrc) | (exFromDec.valid & exFromDec.pcSrc) |
                       (memCtrl.valid & memCtrl.pcSrc);
  assign decCredit   = (decCount != '0) & ~pcWrPending & ~stallE;

endmodule

/* logic/statusReg.sv */
`timescale 1ns/1ps

module statusReg (
  input  logic              clk,
  input  logic              rstN,
  input  logic              en,
  input  logic [1:0]        flagWe,     // {NZ, CV}
  input  armPipePkg::flagsT flagsNext,
  output armPipePkg::flagsT flags
);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (en) begin
      if (flagWe[1]) begin
        flags.n <= flagsNext.n;
        flags.z <= flagsNext.z;
      end
      if (flagWe[0]) begin
        flags.c <= flagsNext.c;
        flags.v <= flagsNext.v;
      end
    end
  end

endmodule

/* verif/armController_properties.sv */
`timescale 1ns/1ps

module armControllerProps #(
  parameter int WbCredits = 2
) (
  input logic                             clk,
  input logic                             rstN,
  input logic                             instrValid,
  input logic                             decCredit,
  input logic                             stallE,
  input armPipePkg::wbCtrlT               wbCtrl,
  input logic [$clog2(WbCredits+1)-1:0]   wbCount
);

  logic [1:0] heldCredits;  // Decode credits owned by fetch

  always_ff @(posedge clk) begin
    if (!rstN) heldCredits <= '0;
    else heldCredits <= heldCredits + 2'(decCredit) - 2'(instrValid);
  end

  sendWithCredit: assert property (@(posedge clk) disable iff (!rstN)
    instrValid |-> heldCredits != '0)
    else $error("instrValid without a held decode credit");

  creditBound: assert property (@(posedge clk) disable iff (!rstN)
    wbCount <= WbCredits)
    else $error("writeback credit count above limit");

  stallBubble: assert property (@(posedge clk) disable iff (!rstN)
    (stallE || wbCount == '0) |=> !wbCtrl.valid)
    else $error("writeback took an item while stalled");

endmodule

bind armController armControllerProps #(.WbCredits(WbCredits)) armControllerProps_inst (
  .clk        (clk),
  .rstN       (rstN),
  .instrValid (instrValid),
  .decCredit  (decCredit),
  .stallE     (stallE),
  .wbCtrl     (wbCtrl),
  .wbCount    (pipeCtrl_inst.wbCount)
);

/* verif/armController_tb.sv */
`timescale 1ns/1ps

module armController_tb;
  import armPipePkg::*;

  localparam int WbCredits = 2;
  localparam int MaxVec    = 64;

  logic    clk;
  logic    rstN;
  logic    instrValid;
  logic [31:0] instr;
  logic    decCredit;
  flagsT   aluFlags;
  exCtrlT  exCtrl;
  logic    stallE;
  memCtrlT memCtrl;
  wbCtrlT  wbCtrl;
  logic    wbCreditReturn;
  logic    pcWrPending;

  // One entry per file line
  logic [31:0] vInstr    [MaxVec];
  logic [3:0]  vAluFlags [MaxVec];
  logic        vMemWrite [MaxVec];
  logic        vRegWrite [MaxVec];
  logic        vPcSrc    [MaxVec];
  logic [3:0]  vRd       [MaxVec];
  logic        vBranch   [MaxVec];
  int          vHold     [MaxVec];
  logic [3:0]  vNext     [MaxVec];

  int nVec;
  int sent;
  int leftE;
  int leftM;
  int leftW;
  int credits;
  int pcFlight;
  int outstanding;
  int cycle;
  int flagIdx;
  int seed;
  bit flagPend;
  bit loaded;
  int releaseQ[$];  // Cycle at which each held credit goes back

  armController #(.WbCredits(WbCredits)) armController_inst (
    .clk            (clk),
    .rstN           (rstN),
    .instrValid     (instrValid),
    .instr          (instr),
    .decCredit      (decCredit),
    .aluFlags       (aluFlags),
    .exCtrl         (exCtrl),
    .stallE         (stallE),
    .memCtrl        (memCtrl),
    .wbCtrl         (wbCtrl),
    .wbCreditReturn (wbCreditReturn),
    .pcWrPending    (pcWrPending)
  );

  task automatic checkValue(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      $display("ERROR %s: actual 0x%0h expected 0x%0h", name, act, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // Branches and data writes to r15 hold fetch while in flight
  function automatic bit setsPc(input logic [31:0] word);
    return (word[27:25] == 3'b101) || (word[27:26] == 2'b00 && word[15:12] == 4'hf);
  endfunction

  function automatic bit isLoad(input logic [31:0] word);
    return (word[27:26] == 2'b01) && word[20];
  endfunction

  task automatic readVectors();
    int    fd;
    int    cnt;
    string line;
    logic [31:0] f[9];
    fd = $fopen("verif/armCtrlTests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test vector file");
      $display("TEST FAILED");
      $fatal(1);
    end
    while (!$feof(fd) && nVec < MaxVec) begin
      line = "";
      cnt  = $fgets(line, fd);
      if (cnt > 0 && line.len() > 1 && line.getc(0) != "#") begin
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
        if (cnt == 9) begin
          vInstr[nVec]    = f[0];
          vAluFlags[nVec] = f[1][3:0];
          vMemWrite[nVec] = f[2][0];
          vRegWrite[nVec] = f[3][0];
          vPcSrc[nVec]    = f[4][0];
          vRd[nVec]       = f[5][3:0];
          vBranch[nVec]   = f[6][0];
          vHold[nVec]     = f[7];
          vNext[nVec]     = f[8][3:0];
          nVec++;
        end
      end
    end
    $fclose(fd);
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    seed = 69845;
    rstN = 1'b0;
    instrValid = 1'b0;
    instr = '0;
    aluFlags = '0;
    wbCreditReturn = 1'b0;
    readVectors();
    loaded = 1'b1;
    repeat (4) @(posedge clk);
    #2 rstN = 1'b1;
    wait (leftW == nVec);
    repeat (5) @(posedge clk);
    if (nVec > 0 && sent == nVec && leftM == nVec) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("Not every vector was sent and retired in order");
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  initial begin
    wait (loaded);
    repeat (nVec * 50 + 100) @(posedge clk);
    $display("Timed out waiting for all instructions to reach writeback");
    $display("TEST FAILED");
    $fatal(1);
  end

  // Stimulus a little after the rising edge
  always @(posedge clk) begin
    if (rstN) begin
      #2;
      cycle++;
      instrValid = 1'b0;
      if (credits > 0 && sent < nVec) begin
        instr      = vInstr[sent];
        instrValid = 1'b1;
        credits--;
        if (setsPc(vInstr[sent])) pcFlight++;
        sent++;
      end
      wbCreditReturn = 1'b0;
      if (releaseQ.size() > 0 && releaseQ[0] <= cycle) begin
        wbCreditReturn = 1'b1;
        void'(releaseQ.pop_front());
        outstanding--;
      end
      if (leftE < nVec) aluFlags = flagsT'(vAluFlags[leftE]);
      else aluFlags = flagsT'($random(seed));
    end
  end

  always @(negedge clk) begin
    if (rstN) begin
      if (flagPend) begin  // Status written at the last edge
        checkValue("flags", armController_inst.flags, vNext[flagIdx]);
        flagPend = 1'b0;
      end
      if (wbCtrl.valid) begin
        checkValue("wbCtrl.regWrite", wbCtrl.regWrite, vRegWrite[leftW]);
        checkValue("wbCtrl.pcSrc", wbCtrl.pcSrc, vPcSrc[leftW]);
        checkValue("wbCtrl.rd", wbCtrl.rd, vRd[leftW]);
        checkValue("wbCtrl.memToReg", wbCtrl.memToReg, isLoad(vInstr[leftW]));
        releaseQ.push_back(cycle + vHold[leftW]);
        outstanding++;
        checkValue("outstanding credits over limit", outstanding > WbCredits, 0);
        if (setsPc(vInstr[leftW]) && vPcSrc[leftW]) pcFlight--;
        leftW++;
      end
      // M item waits while every credit is out
      checkValue("stallE", stallE,
                 (leftE > leftM) && (outstanding + int'(wbCreditReturn) >= WbCredits));
      checkValue("pcWrPending", pcWrPending, pcFlight > 0);
      if (pcFlight > 0) checkValue("decCredit", decCredit, 0);
      if (decCredit) credits++;
      if (exCtrl.valid) begin
        checkValue("exCtrl.branchTaken", exCtrl.branchTaken, vBranch[leftE]);
        if (!stallE) begin
          if (setsPc(vInstr[leftE]) && !vPcSrc[leftE]) pcFlight--;  // PC write squashed
          flagIdx  = leftE;
          flagPend = 1'b1;
          leftE++;
        end
      end
      if (memCtrl.valid && !stallE) begin
        checkValue("memCtrl.memWrite", memCtrl.memWrite, vMemWrite[leftM]);
        leftM++;
      end
    end
  end

endmodule

/* verif/armCtrlTests.txt */
# instr aluFlags memWrite regWrite pcSrc rd branchTaken hold nextFlags
# hex fields, flags as nzcv, hold in cycles before a credit returns
E3A01005 0 0 1 0 1 0 0 0
E2513005 6 0 1 0 3 0 0 6
E3510005 6 0 0 0 0 0 5 6
03A04007 0 0 1 0 4 0 5 6
13A05007 0 0 0 0 5 0 5 6
12916001 8 0 0 0 6 0 0 6
E5802004 0 1 0 0 2 0 0 6
E5907008 0 0 1 0 7 0 1 6
15802000 0 0 0 0 2 0 0 6
0A000002 0 0 0 1 0 1 3 6
1A000002 0 0 0 0 0 0 0 6
E0080291 0 0 1 0 8 0 0 6
E1A0F000 0 0 1 1 F 0 0 6
E3110000 4 0 0 0 0 0 6 4
E3919000 8 0 1 0 9 0 6 8
B3A0A001 0 0 1 0 A 0 0 8
